// ==== source/neuronPkg.sv ====
// neuron core shared definitions
// widths, bus and packet structs, controller state encoding

package neuronPkg;

	// data and counter widths
	localparam int DSIZE      = 16;
	localparam int NURN_ID_W  = 8;
	localparam int STEP_W     = 16;
	localparam int APB_ADDR_W = 12;

	// host driven side of the APB port
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [31:0]           pwdata;
	} apbReq_t;

	// slave driven side of the APB port
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRsp_t;

	typedef struct packed {
		logic [STEP_W-1:0]    step;
		logic [NURN_ID_W-1:0] nurnId;
	} spikePkt_t;

	typedef struct packed {
		logic signed [DSIZE-1:0] thresh;
		logic signed [DSIZE-1:0] rstPot;
	} nurnCfg_t;

	typedef enum logic [1:0] {IDLE, ACCUM, FIRE, STALL} ctrlState_t;

endpackage

// ==== source/nurnConfigApb.sv ====
// neuron configuration storage
// APB slave for weights, thresholds and reset potentials, with read ports to the core

`timescale 1ns/10ps

module nurnConfigApb #(
	parameter int NUM_NURNS = 4,
	parameter int NUM_AXONS = 8,
	localparam int NURN_AW = (NUM_NURNS > 1) ? $clog2(NUM_NURNS) : 1,
	localparam int AXON_AW = (NUM_AXONS > 1) ? $clog2(NUM_AXONS) : 1
) (
	input  logic                          clk_i,
	input  logic                          rstN_i,
	input  neuronPkg::apbReq_t            apbReq_i,
	output neuronPkg::apbRsp_t            apbRsp_o,
	input  logic                          busy_i,
	input  logic [neuronPkg::STEP_W-1:0]  stepCnt_i,
	input  logic [NURN_AW-1:0]            nurnAddr_i,
	input  logic [AXON_AW-1:0]            axonAddr_i,
	output logic signed [neuronPkg::DSIZE-1:0] weight_o,
	output neuronPkg::nurnCfg_t           nurnCfg_o
);

	localparam int NUM_W = NUM_NURNS * NUM_AXONS;
	localparam int W_AW  = (NUM_W > 1) ? $clog2(NUM_W) : 1;

	logic signed [neuronPkg::DSIZE-1:0] weights [NUM_W];
	logic signed [neuronPkg::DSIZE-1:0] thresh [NUM_NURNS];
	logic signed [neuronPkg::DSIZE-1:0] rstPot [NUM_NURNS];

	logic        access;
	logic        inRange;
	logic        err;
	logic        wrEn;
	logic [1:0]  region;
	logic [7:0]  wordIdx;
	logic [31:0] rdData;

	//----------------------------------------------------------------------------
	// address decode and read mux
	//----------------------------------------------------------------------------
	assign access  = apbReq_i.psel & apbReq_i.penable;
	assign region  = apbReq_i.paddr[11:10];
	assign wordIdx = apbReq_i.paddr[9:2];

	always_comb begin
		inRange = 1'b0;
		rdData  = '0;
		case (region)
			2'd0: begin
				inRange = int'(wordIdx) < NUM_W;
				if (inRange)
					rdData = 32'(weights[wordIdx[W_AW-1:0]]);
			end
			2'd1: begin
				inRange = int'(wordIdx) < NUM_NURNS;
				if (inRange)
					rdData = 32'(thresh[wordIdx[NURN_AW-1:0]]);
			end
			2'd2: begin
				inRange = int'(wordIdx) < NUM_NURNS;
				if (inRange)
					rdData = 32'(rstPot[wordIdx[NURN_AW-1:0]]);
			end
			default: begin
				// step count, unsigned
				inRange = 1'b1;
				rdData  = {16'b0, stepCnt_i};
			end
		endcase
	end

	assign err  = access & (~inRange | (apbReq_i.pwrite & ((region == 2'd3) | busy_i)));
	assign wrEn = access & apbReq_i.pwrite & ~err;

	// zero wait state slave
	assign apbRsp_o.pready  = 1'b1;
	assign apbRsp_o.pslverr = err;
	assign apbRsp_o.prdata  = (access & ~apbReq_i.pwrite & ~err) ? rdData : '0;

	//----------------------------------------------------------------------------
	// register arrays
	//----------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < NUM_W; i++)
				weights[i] <= '0;
			for (int i = 0; i < NUM_NURNS; i++) begin
				thresh[i] <= '0;
				rstPot[i] <= '0;
			end
		end else if (wrEn) begin
			case (region)
				2'd0: weights[wordIdx[W_AW-1:0]] <= apbReq_i.pwdata[15:0];
				2'd1: thresh[wordIdx[NURN_AW-1:0]] <= apbReq_i.pwdata[15:0];
				2'd2: rstPot[wordIdx[NURN_AW-1:0]] <= apbReq_i.pwdata[15:0];
				default: ;
			endcase
		end
	end

	// read ports for the processing part
	assign weight_o = weights[W_AW'(int'(nurnAddr_i) * NUM_AXONS + int'(axonAddr_i))];
	assign nurnCfg_o.thresh = thresh[nurnAddr_i];
	assign nurnCfg_o.rstPot = rstPot[nurnAddr_i];

endmodule

// ==== source/inSpikeBuf.sv ====
// input spike buffer
// holds the axon spike vector for the running time step

`timescale 1ns/10ps

module inSpikeBuf #(
	parameter int NUM_AXONS = 8,
	localparam int AXON_AW = (NUM_AXONS > 1) ? $clog2(NUM_AXONS) : 1
) (
	input  logic                 clk_i,
	input  logic                 rstN_i,
	input  logic                 start_i,
	input  logic                 busy_i,
	input  logic [NUM_AXONS-1:0] spikeIn_i,
	input  logic [AXON_AW-1:0]   axonAddr_i,
	output logic                 axonSpike_o
);

	logic [NUM_AXONS-1:0] spikeReg;

	// capture only on a start taken while idle
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i)
			spikeReg <= '0;
		else if (start_i && !busy_i)
			spikeReg <= spikeIn_i;
	end

	// one bit per axon, read combinationally
	assign axonSpike_o = spikeReg[axonAddr_i];

endmodule

// ==== source/nurnCtrlr.sv ====
// neuron controller
// walks neurons and axons per time step, stalls on a full output and counts steps

`timescale 1ns/10ps

module nurnCtrlr #(
	parameter int NUM_NURNS = 4,
	parameter int NUM_AXONS = 8,
	localparam int NURN_AW = (NUM_NURNS > 1) ? $clog2(NUM_NURNS) : 1,
	localparam int AXON_AW = (NUM_AXONS > 1) ? $clog2(NUM_AXONS) : 1
) (
	input  logic                         clk_i,
	input  logic                         rstN_i,
	input  logic                         start_i,
	input  logic                         fifoFull_i,
	input  logic                         fired_i,
	output logic                         busy_o,
	output logic                         done_o,
	output logic [NURN_AW-1:0]           nurnAddr_o,
	output logic [AXON_AW-1:0]           axonAddr_o,
	output logic                         accEn_o,
	output logic                         clrAcc_o,
	output logic                         fireCmp_o,
	output logic                         pktPush_o,
	output neuronPkg::spikePkt_t         pkt_o,
	output logic [neuronPkg::STEP_W-1:0] stepCnt_o
);

	neuronPkg::ctrlState_t state;
	logic [NURN_AW-1:0] nurnCnt;
	logic [AXON_AW-1:0] axonCnt;
	logic [neuronPkg::STEP_W-1:0] stepCnt;

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			state   <= neuronPkg::IDLE;
			nurnCnt <= '0;
			axonCnt <= '0;
			stepCnt <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				neuronPkg::IDLE: begin
					nurnCnt <= '0;
					axonCnt <= '0;
					if (start_i)
						state <= neuronPkg::ACCUM;
				end
				neuronPkg::ACCUM: begin
					if (axonCnt == AXON_AW'(NUM_AXONS - 1)) begin
						axonCnt <= '0;
						// hold off the compare until there is room for a packet
						state   <= fifoFull_i ? neuronPkg::STALL : neuronPkg::FIRE;
					end else begin
						axonCnt <= axonCnt + 1'b1;
					end
				end
				neuronPkg::STALL: begin
					if (!fifoFull_i)
						state <= neuronPkg::FIRE;
				end
				default: begin
					if (nurnCnt == NURN_AW'(NUM_NURNS - 1)) begin
						state   <= neuronPkg::IDLE;
						done_o  <= 1'b1;
						stepCnt <= stepCnt + 1'b1;
					end else begin
						nurnCnt <= nurnCnt + 1'b1;
						state   <= neuronPkg::ACCUM;
					end
				end
			endcase
		end
	end

	assign busy_o     = (state != neuronPkg::IDLE);
	assign nurnAddr_o = nurnCnt;
	assign axonAddr_o = axonCnt;
	assign accEn_o    = (state == neuronPkg::ACCUM);
	assign fireCmp_o  = (state == neuronPkg::FIRE);
	// accumulator starts clean for every neuron
	assign clrAcc_o   = (state == neuronPkg::IDLE) | (state == neuronPkg::FIRE);

	assign pktPush_o    = fireCmp_o & fired_i;
	assign pkt_o.step   = stepCnt;
	assign pkt_o.nurnId = neuronPkg::NURN_ID_W'(nurnCnt);
	assign stepCnt_o    = stepCnt;

endmodule

// ==== source/nurnDataPath.sv ====
// neuron datapath
// saturating accumulator, threshold compare and membrane potential storage

`timescale 1ns/10ps

module nurnDataPath #(
	parameter int NUM_NURNS = 4,
	localparam int NURN_AW = (NUM_NURNS > 1) ? $clog2(NUM_NURNS) : 1
) (
	input  logic                               clk_i,
	input  logic                               rstN_i,
	input  logic                               accEn_i,
	input  logic                               clrAcc_i,
	input  logic                               fireCmp_i,
	input  logic [NURN_AW-1:0]                 nurnAddr_i,
	input  logic                               axonSpike_i,
	input  logic signed [neuronPkg::DSIZE-1:0] weight_i,
	input  neuronPkg::nurnCfg_t                nurnCfg_i,
	output logic                               fired_o
);

	localparam int DW = neuronPkg::DSIZE;

	logic signed [DW-1:0] acc;
	logic signed [DW-1:0] membPot [NUM_NURNS];
	logic signed [DW-1:0] newPot;

	// signed add clamped to the 16 bit range
	function automatic logic signed [DW-1:0] satAdd(
		input logic signed [DW-1:0] a,
		input logic signed [DW-1:0] b
	);
		logic signed [DW:0] s;
		s = {a[DW-1], a} + {b[DW-1], b};
		if (s[DW] != s[DW-1])
			return s[DW] ? {1'b1, {(DW-1){1'b0}}} : {1'b0, {(DW-1){1'b1}}};
		return s[DW-1:0];
	endfunction

	//----------------------------------------------------------------------------
	// accumulate one axon per cycle
	//----------------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i)
			acc <= '0;
		else if (clrAcc_i)
			acc <= '0;
		else if (accEn_i && axonSpike_i)
			acc <= satAdd(acc, weight_i);
	end

	//----------------------------------------------------------------------------
	// compare and write back in the fire cycle
	//----------------------------------------------------------------------------
	assign newPot  = satAdd(membPot[nurnAddr_i], acc);
	assign fired_o = fireCmp_i & (newPot >= nurnCfg_i.thresh);

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < NUM_NURNS; i++)
				membPot[i] <= '0;
		end else if (fireCmp_i) begin
			membPot[nurnAddr_i] <= fired_o ? nurnCfg_i.rstPot : newPot;
		end
	end

endmodule

// ==== source/spikeOut.sv ====
// spike output queue
// four entry packet FIFO feeding the valid/ready spike stream

`timescale 1ns/10ps

module spikeOut (
	input  logic                 clk_i,
	input  logic                 rstN_i,
	input  logic                 push_i,
	input  neuronPkg::spikePkt_t pkt_i,
	output logic                 full_o,
	output logic                 spikeValid_o,
	output neuronPkg::spikePkt_t spike_o,
	input  logic                 spikeReady_i
);

	neuronPkg::spikePkt_t mem [4];
	logic [1:0] wrPtr;
	logic [1:0] rdPtr;
	logic [2:0] count;
	logic       doPush;
	logic       doPop;

	assign doPush = push_i & ~full_o;
	assign doPop  = spikeValid_o & spikeReady_i;

	always_ff @(posedge clk_i) begin
		if (doPush)
			mem[wrPtr] <= pkt_i;
	end

	always_ff @(posedge clk_i or negedge rstN_i) begin
		if (!rstN_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + 3'(doPush) - 3'(doPop);
		end
	end

	// head entry holds still until the sink takes it
	assign full_o       = (count == 3'd4);
	assign spikeValid_o = (count != 3'd0);
	assign spike_o      = mem[rdPtr];

endmodule

// ==== source/neuron.sv ====
// neuron core top level
// integrate-and-fire neurons with APB configuration and a spike packet stream

`timescale 1ns/10ps

module neuron #(
	parameter int NUM_NURNS = 4,
	parameter int NUM_AXONS = 8,
	localparam int NURN_AW = (NUM_NURNS > 1) ? $clog2(NUM_NURNS) : 1,
	localparam int AXON_AW = (NUM_AXONS > 1) ? $clog2(NUM_AXONS) : 1
) (
	input  logic                 clk_i,
	input  logic                 rstN_i,
	input  neuronPkg::apbReq_t   apbReq_i,
	output neuronPkg::apbRsp_t   apbRsp_o,
	input  logic                 start_i,
	input  logic [NUM_AXONS-1:0] spikeIn_i,
	output logic                 busy_o,
	output logic                 done_o,
	output logic                 spikeValid_o,
	output neuronPkg::spikePkt_t spike_o,
	input  logic                 spikeReady_i
);

	logic [NURN_AW-1:0]                 nurnAddr;
	logic [AXON_AW-1:0]                 axonAddr;
	logic                               axonSpike;
	logic signed [neuronPkg::DSIZE-1:0] weight;
	neuronPkg::nurnCfg_t                nurnCfg;
	logic [neuronPkg::STEP_W-1:0]       stepCnt;
	logic                               accEn;
	logic                               clrAcc;
	logic                               fireCmp;
	logic                               fired;
	logic                               pktPush;
	neuronPkg::spikePkt_t               pkt;
	logic                               fifoFull;

	//----------------------------------------------------------------------------
	// input side
	//----------------------------------------------------------------------------
	nurnConfigApb #(.NUM_NURNS(NUM_NURNS), .NUM_AXONS(NUM_AXONS)) configApb (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.apbReq_i   (apbReq_i),
		.apbRsp_o   (apbRsp_o),
		.busy_i     (busy_o),
		.stepCnt_i  (stepCnt),
		.nurnAddr_i (nurnAddr),
		.axonAddr_i (axonAddr),
		.weight_o   (weight),
		.nurnCfg_o  (nurnCfg)
	);

	inSpikeBuf #(.NUM_AXONS(NUM_AXONS)) spikeBuf (
		.clk_i       (clk_i),
		.rstN_i      (rstN_i),
		.start_i     (start_i),
		.busy_i      (busy_o),
		.spikeIn_i   (spikeIn_i),
		.axonAddr_i  (axonAddr),
		.axonSpike_o (axonSpike)
	);

	//----------------------------------------------------------------------------
	// processing part
	//----------------------------------------------------------------------------
	nurnCtrlr #(.NUM_NURNS(NUM_NURNS), .NUM_AXONS(NUM_AXONS)) ctrlr (
		.clk_i      (clk_i),
		.rstN_i     (rstN_i),
		.start_i    (start_i),
		.fifoFull_i (fifoFull),
		.fired_i    (fired),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.nurnAddr_o (nurnAddr),
		.axonAddr_o (axonAddr),
		.accEn_o    (accEn),
		.clrAcc_o   (clrAcc),
		.fireCmp_o  (fireCmp),
		.pktPush_o  (pktPush),
		.pkt_o      (pkt),
		.stepCnt_o  (stepCnt)
	);

	nurnDataPath #(.NUM_NURNS(NUM_NURNS)) dataPath (
		.clk_i       (clk_i),
		.rstN_i      (rstN_i),
		.accEn_i     (accEn),
		.clrAcc_i    (clrAcc),
		.fireCmp_i   (fireCmp),
		.nurnAddr_i  (nurnAddr),
		.axonSpike_i (axonSpike),
		.weight_i    (weight),
		.nurnCfg_i   (nurnCfg),
		.fired_o     (fired)
	);

	// output side
	spikeOut outQueue (
		.clk_i        (clk_i),
		.rstN_i       (rstN_i),
		.push_i       (pktPush),
		.pkt_i        (pkt),
		.full_o       (fifoFull),
		.spikeValid_o (spikeValid_o),
		.spike_o      (spike_o),
		.spikeReady_i (spikeReady_i)
	);

endmodule

// ==== test/neuron_assert.sv ====
// neuron core protocol checks
// stream stability, APB ready, done pulse and reset values

`timescale 1ns/10ps

module neuron_assert (
	input logic                 clk_i,
	input logic                 rstN_i,
	input neuronPkg::apbRsp_t   apbRsp_i,
	input logic                 busy_i,
	input logic                 done_i,
	input logic                 spikeValid_i,
	input neuronPkg::spikePkt_t spike_i,
	input logic                 spikeReady_i
);

	// head packet must hold while the sink stalls
	assert property (@(posedge clk_i) disable iff (!rstN_i)
		spikeValid_i && !spikeReady_i |=> spikeValid_i && $stable(spike_i))
		else $error("spike packet changed or dropped while stalled");

	assert property (@(posedge clk_i) disable iff (!rstN_i) apbRsp_i.pready)
		else $error("APB pready low");

	assert property (@(posedge clk_i) disable iff (!rstN_i)
		done_i |-> $past(busy_i) && !busy_i)
		else $error("done without busy falling");

	assert property (@(posedge clk_i) disable iff (!rstN_i) done_i |=> !done_i)
		else $error("done longer than one cycle");

	assert property (@(posedge clk_i)
		!rstN_i |-> !busy_i && !done_i && !spikeValid_i && !apbRsp_i.pslverr)
		else $error("outputs not idle in reset");

endmodule

bind neuron neuron_assert assertChk (
	.clk_i        (clk_i),
	.rstN_i       (rstN_i),
	.apbRsp_i     (apbRsp_o),
	.busy_i       (busy_o),
	.done_i       (done_o),
	.spikeValid_i (spikeValid_o),
	.spike_i      (spike_o),
	.spikeReady_i (spikeReady_i)
);

// ==== test/neuronTb.sv ====
// neuron core testbench
// APB configuration, time steps against a reference model, output back-pressure

`timescale 1ns/10ps

module neuronTb;

	localparam int NN = 4;
	localparam int NA = 8;

	logic                 clk;
	logic                 rstN;
	neuronPkg::apbReq_t   apbReq;
	neuronPkg::apbRsp_t   apbRsp;
	logic                 start;
	logic [NA-1:0]        spikeIn;
	logic                 busy;
	logic                 done;
	logic                 spikeValid;
	neuronPkg::spikePkt_t spike;
	logic                 spikeReady;

	// shadow state of the core
	logic signed [15:0] shW [NN*NA];
	logic signed [15:0] shThr [NN];
	logic signed [15:0] shRst [NN];
	logic signed [15:0] shPot [NN];
	neuronPkg::spikePkt_t expQ [$];
	int stepNum;
	logic [31:0] lfsr;
	logic [31:0] readyLfsr;
	logic randReady;
	logic [NN-1:0] mask;

	neuron #(.NUM_NURNS(NN), .NUM_AXONS(NA)) dut (
		.clk_i        (clk),
		.rstN_i       (rstN),
		.apbReq_i     (apbReq),
		.apbRsp_o     (apbRsp),
		.start_i      (start),
		.spikeIn_i    (spikeIn),
		.busy_o       (busy),
		.done_o       (done),
		.spikeValid_o (spikeValid),
		.spike_o      (spike),
		.spikeReady_i (spikeReady)
	);

	always #10 clk = ~clk;

	//--------------------------------------------------------------------------
	// error reporting, random bits, reference model
	//--------------------------------------------------------------------------
	task automatic reportMismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportFailure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic logic signed [15:0] satRef(input logic signed [15:0] a,
		input logic signed [15:0] b);
		int s;
		s = int'(a) + int'(b);
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return 16'(s);
	endfunction

	// one time step over the shadow state, returns the firing neurons
	function automatic logic [NN-1:0] refStep(input logic [NA-1:0] spk);
		logic [NN-1:0] fired;
		logic signed [15:0] acc;
		logic signed [15:0] pot;
		fired = '0;
		for (int n = 0; n < NN; n++) begin
			acc = '0;
			for (int a = 0; a < NA; a++)
				if (spk[a])
					acc = satRef(acc, shW[n*NA+a]);
			pot = satRef(shPot[n], acc);
			if (pot >= shThr[n]) begin
				fired[n] = 1'b1;
				shPot[n] = shRst[n];
			end else begin
				shPot[n] = pot;
			end
		end
		return fired;
	endfunction

	//--------------------------------------------------------------------------
	// bus and step tasks
	//--------------------------------------------------------------------------
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int cnt;
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = wr;
		apbReq.paddr   = addr;
		apbReq.pwdata  = wdata;
		tick();
		apbReq.penable = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!apbRsp.pready) begin
			cnt++;
			assert (cnt < 100) else reportFailure("APB transfer got no pready");
			@(negedge clk);
		end
		rdata = apbRsp.prdata;
		err   = apbRsp.pslverr;
		tick();
		apbReq = '0;
	endtask

	task automatic cfgWrite(input logic [11:0] addr, input logic [31:0] wdata, input logic expErr);
		logic [31:0] rdata;
		logic err;
		apbXfer(1'b1, addr, wdata, rdata, err);
		assert (err == expErr)
			else reportMismatch($sformatf("write %h pslverr %0b, expected %0b", addr, err, expErr));
	endtask

	task automatic cfgRead(input logic [11:0] addr, input logic [31:0] expData, input logic expErr);
		logic [31:0] rdata;
		logic err;
		apbXfer(1'b0, addr, '0, rdata, err);
		assert (err == expErr)
			else reportMismatch($sformatf("read %h pslverr %0b, expected %0b", addr, err, expErr));
		assert (expErr || rdata == expData)
			else reportMismatch($sformatf("read %h gave %h, expected %h", addr, rdata, expData));
	endtask

	task automatic setWeight(input int n, input int a, input logic signed [15:0] val);
		cfgWrite(12'((n * NA + a) * 4), 32'(val), 1'b0);
		shW[n*NA+a] = val;
	endtask

	task automatic setThr(input int n, input logic signed [15:0] val);
		cfgWrite(12'h400 + 12'(n * 4), 32'(val), 1'b0);
		shThr[n] = val;
	endtask

	task automatic setRst(input int n, input logic signed [15:0] val);
		cfgWrite(12'h800 + 12'(n * 4), 32'(val), 1'b0);
		shRst[n] = val;
	endtask

	task automatic launchStep(input logic [NA-1:0] spk, output logic [NN-1:0] fired);
		neuronPkg::spikePkt_t pkt;
		fired = refStep(spk);
		for (int n = 0; n < NN; n++) begin
			if (fired[n]) begin
				pkt.step   = 16'(stepNum);
				pkt.nurnId = 8'(n);
				expQ.push_back(pkt);
			end
		end
		start   = 1'b1;
		spikeIn = spk;
		tick();
		start = 1'b0;
		stepNum++;
	endtask

	task automatic waitDone();
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!done) begin
			cnt++;
			assert (cnt < 3000) else reportFailure("time step did not finish");
			@(negedge clk);
		end
		tick();
	endtask

	task automatic runStep(input logic [NA-1:0] spk, output logic [NN-1:0] fired);
		launchStep(spk, fired);
		waitDone();
	endtask

	task automatic waitDrain();
		int cnt;
		cnt = 0;
		while (expQ.size() != 0) begin
			cnt++;
			assert (cnt < 3000) else reportFailure("expected spike packets never arrived");
			tick();
		end
	endtask

	//--------------------------------------------------------------------------
	// sink side and packet compare
	//--------------------------------------------------------------------------
	always @(posedge clk) begin
		#2;
		if (randReady) begin
			// ready high about one cycle in sixteen, so the FIFO fills up
			for (int i = 0; i < 4; i++)
				readyLfsr = lfsrNext(readyLfsr);
			spikeReady = &readyLfsr[3:0];
		end else begin
			spikeReady = 1'b1;
		end
	end

	// valid and ready at the negedge mean a transfer on the next rising edge
	always @(negedge clk) begin : comparePkt
		neuronPkg::spikePkt_t expPkt;
		if (rstN && spikeValid && spikeReady) begin
			assert (expQ.size() > 0) else reportFailure("spike packet arrived unexpectedly");
			expPkt = expQ.pop_front();
			assert (spike == expPkt)
				else reportMismatch($sformatf("packet neuron %0d step %0d, expected neuron %0d step %0d",
					spike.nurnId, spike.step, expPkt.nurnId, expPkt.step));
		end
	end

	//--------------------------------------------------------------------------
	// main sequence
	//--------------------------------------------------------------------------
	initial begin
		clk        = 1'b0;
		rstN       = 1'b0;
		apbReq     = '0;
		start      = 1'b0;
		spikeIn    = '0;
		spikeReady = 1'b1;
		randReady  = 1'b0;
		lfsr       = 32'hfdf2;
		readyLfsr  = 32'hfdf2;
		stepNum    = 0;
		for (int i = 0; i < NN * NA; i++)
			shW[i] = '0;
		for (int n = 0; n < NN; n++) begin
			shThr[n] = '0;
			shRst[n] = '0;
			shPot[n] = '0;
		end
		repeat (10) @(posedge clk);
		#2;
		rstN = 1'b1;
		tick();

		// register access, sign extension and error responses
		cfgWrite(12'd44, 32'habcd_8001, 1'b0);
		cfgWrite(12'h408, 32'h0000_7fff, 1'b0);
		cfgWrite(12'h80c, 32'h1234_ff00, 1'b0);
		cfgRead(12'd44, 32'hffff_8001, 1'b0);
		cfgRead(12'h408, 32'h0000_7fff, 1'b0);
		cfgRead(12'h80c, 32'hffff_ff00, 1'b0);
		cfgWrite(12'd128, 32'h1111, 1'b1);
		cfgWrite(12'h410, 32'h2222, 1'b1);
		cfgWrite(12'h810, 32'h3333, 1'b1);
		cfgWrite(12'hc00, 32'h0055, 1'b1);
		cfgRead(12'd128, '0, 1'b1);
		cfgRead(12'd44, 32'hffff_8001, 1'b0);
		cfgRead(12'h408, 32'h0000_7fff, 1'b0);
		cfgRead(12'h80c, 32'hffff_ff00, 1'b0);
		// entries the out of range indices wrap onto
		cfgRead(12'd0, 32'h0, 1'b0);
		cfgRead(12'h400, 32'h0, 1'b0);
		cfgRead(12'h800, 32'h0, 1'b0);
		cfgRead(12'hc00, 32'h0, 1'b0);
		shW[11]  = 16'sh8001;
		shThr[2] = 16'sh7fff;
		shRst[3] = 16'shff00;

		// single step, axons 0 and 2 spiking
		setThr(0, 16'sd10);
		setThr(1, 16'sd100);
		setThr(2, 16'sd5);
		setThr(3, 16'sd32767);
		setRst(0, 16'sd0);
		setRst(1, -16'sd100);
		setRst(2, 16'sd0);
		setRst(3, 16'sd1000);
		setWeight(0, 0, 16'sd6);
		setWeight(0, 2, 16'sd4);
		setWeight(1, 0, 16'sd50);
		setWeight(1, 2, 16'sd49);
		setWeight(2, 0, -16'sd3);
		setWeight(2, 2, 16'sd9);
		runStep(8'h05, mask);
		assert (mask == 4'b0101) else reportMismatch("step 0 firing set differs from 4'b0101");
		waitDrain();
		cfgRead(12'hc00, 32'd1, 1'b0);

		// accumulation across steps, restart from reset potential, saturation
		setWeight(3, 0, 16'sd30000);
		setWeight(3, 2, 16'sd30000);
		for (int i = 0; i < 3; i++) begin
			runStep(8'h05, mask);
			assert (mask[1] == (i == 0)) else reportMismatch("neuron 1 firing pattern wrong");
			assert (mask[3]) else reportMismatch("neuron 3 did not fire on saturated sum");
		end
		waitDrain();

		// random weights and spikes
		for (int n = 0; n < NN; n++) begin
			for (int a = 0; a < NA; a++)
				setWeight(n, a, 16'(signed'(8'(randBits(8)))));
			setThr(n, 16'(40 + randBits(7)));
			setRst(n, -16'(randBits(5)));
		end
		for (int i = 0; i < 40; i++)
			runStep(NA'(randBits(NA)), mask);
		waitDrain();

		// back-pressure, start and APB write while busy
		for (int n = 0; n < NN - 1; n++)
			setThr(n, 16'sh8000);
		// neuron 3 fires only when axon 0 spikes
		for (int a = 0; a < NA; a++)
			setWeight(3, a, (a == 0) ? 16'sh7fff : 16'sd0);
		setThr(3, 16'sd1);
		setRst(3, 16'sd0);
		randReady = 1'b1;
		for (int i = 0; i < 6; i++) begin
			launchStep(NA'(randBits(NA)), mask);
			assert (busy) else reportFailure("core not busy after start");
			start   = 1'b1;
			spikeIn = ~spikeIn;
			tick();
			start = 1'b0;
			cfgWrite(12'h400, 32'd7, 1'b1);
			waitDone();
		end
		waitDrain();
		randReady = 1'b0;
		cfgRead(12'h400, 32'hffff_8000, 1'b0);
		cfgRead(12'hc00, 32'(stepNum), 1'b0);

		repeat (10) tick();
		if (expQ.size() != 0) begin
			$display("%0d expected packets left over", expQ.size());
			$display("sim failed");
			$fatal(1, "packets missing at end of run");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
source/neuronPkg.sv
source/nurnConfigApb.sv
source/inSpikeBuf.sv
source/nurnCtrlr.sv
source/nurnDataPath.sv
source/spikeOut.sv
source/neuron.sv
test/neuron_assert.sv
test/neuronTb.sv

// ==== Makefile ====
# Verilator flow for the neuron core testbench

TOP := neuronTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
